// File: list.f
hw/shell_pkg.sv
hw/pipe_stage.sv
hw/host_chan_mux.sv
hw/local_mem_bridge.sv
hw/green_shell_top.sv
tests/green_shell_sva.sv
tests/tb_green_shell.sv

// File: Makefile
# Verilator build and run of the shell testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_green_shell
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tb_green_shell.sv
/*
 * Testbench for the shell top level
 * Wishbone host model, Avalon memory model, stimulus table and compare tasks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_green_shell;

   import shell_pkg::*;

   localparam int NUM_PORTS     = 3;
   localparam int INSTANCE_BASE = 1;
   localparam int RD_DEPTH      = 2;
   localparam int MEM_LAT       = 3;
   localparam int NUM_ENTRIES   = 18;
   localparam int CYCLE_LIMIT   = 40 * NUM_ENTRIES + 200;

   typedef struct packed {
      logic              mem;   // 0 host port, 1 local memory
      logic              all;   // issue on every port at once
      logic [1:0]        port;
      logic              we;
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
      logic [DATA_W-1:0] exp;
   } stim_t;

   logic      Clk_100;
   logic      reset;
   wb_req_t   port_req [NUM_PORTS];
   wb_rsp_t   port_rsp [NUM_PORTS];
   host_req_t host_req;
   wb_rsp_t   host_rsp;
   avmm_req_t lm_afu_req;
   avmm_rsp_t lm_afu_rsp;
   avmm_req_t lm_mem_req;
   avmm_rsp_t lm_mem_rsp;

   stim_t stim [NUM_ENTRIES];
   int    idx;
   int    cycles;
   logic  stim_on;

   // Host model and expected arbiter state
   logic [DATA_W-1:0]    host_store [logic [ADDR_W-1:0]];
   wb_req_t              port_drive [NUM_PORTS];
   logic [DATA_W-1:0]    port_exp [NUM_PORTS];
   logic [NUM_PORTS-1:0] pending;
   logic                 hreq_on;
   logic                 acking;
   int                   cur_win;
   int                   last_win;
   int                   grant_at;
   int                   host_wait;

   // Memory model and expected bridge state
   logic [DATA_W-1:0] mem_store [logic [ADDR_W-1:0]];
   avmm_req_t         afu_cur;
   avmm_req_t         stage_req;
   logic              afu_active;
   logic              stage_full;
   logic              mem_wait;
   logic [DATA_W-1:0] afu_exp;
   int                lat_due [$];
   logic [DATA_W-1:0] lat_word [$];
   logic [DATA_W-1:0] rd_exp_q [$];
   logic              rdv_pipe [RD_DEPTH+1];

   green_shell_top
   #(
      .NUM_PORTS           (NUM_PORTS),
      .INSTANCE_BASE       (INSTANCE_BASE),
      .READDATA_PIPE_DEPTH (RD_DEPTH)
   )
   uut
   (
      .Clk_100    (Clk_100),
      .reset      (reset),
      .port_req   (port_req),
      .port_rsp   (port_rsp),
      .host_req   (host_req),
      .host_rsp   (host_rsp),
      .lm_afu_req (lm_afu_req),
      .lm_afu_rsp (lm_afu_rsp),
      .lm_mem_req (lm_mem_req),
      .lm_mem_rsp (lm_mem_rsp)
   );

   initial Clk_100 = 1'b0;
   always #5 Clk_100 = ~Clk_100;

   // ==================================================================
   // Failure reporting and compare tasks
   // ==================================================================
   task automatic abort_run();
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_wb_rsp(input string name, input wb_rsp_t got, input wb_rsp_t exp);
      if (got !== exp)
      begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   // Payload and tag only matter while a request is up
   task automatic check_host_req(input string name, input host_req_t got, input host_req_t exp);
      if ((got.req.cyc !== exp.req.cyc) || (got.req.stb !== exp.req.stb) ||
          (exp.req.cyc && (got !== exp)))
      begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_avmm_req(input string name, input avmm_req_t got, input avmm_req_t exp);
      if ((got.read !== exp.read) || (got.write !== exp.write) ||
          ((exp.read || exp.write) && (got !== exp)))
      begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_avmm_rsp(input string name, input avmm_rsp_t got, input avmm_rsp_t exp);
      if ((got.waitrequest !== exp.waitrequest) || (got.readdatavalid !== exp.readdatavalid) ||
          (exp.readdatavalid && (got.readdata !== exp.readdata)))
      begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   // ==================================================================
   // Reference models
   // ==================================================================

   // Unwritten words read back as a pattern of their address
   function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] adr);
      return ~adr;
   endfunction

   // First pending port after the last winner
   function automatic int next_winner();
      int p;
      for (int i = 1; i <= NUM_PORTS; i++)
      begin
         p = (last_win + i) % NUM_PORTS;
         if (pending[p])
            return p;
      end
      return 0;
   endfunction

   function automatic bit drained();
      return (idx == NUM_ENTRIES) && (pending == '0) && !hreq_on && !afu_active &&
             !stage_full && (lat_due.size() == 0) && (rd_exp_q.size() == 0);
   endfunction

   task automatic start_entry(input stim_t s);
      int off;
      if (s.mem)
      begin
         afu_cur = '{read: ~s.we, write: s.we, address: s.adr, writedata: s.dat,
                     byteenable: {SEL_W{1'b1}}};
         afu_exp    = s.exp;
         afu_active = 1'b1;
      end
      else
      begin
         for (int p = 0; p < NUM_PORTS; p++)
         begin
            if (s.all || (p == int'(s.port)))
            begin
               off = s.all ? p : 0;
               port_drive[p] = '{cyc: 1'b1, stb: 1'b1, we: s.we,
                                 adr: s.adr + ADDR_W'(4 * off), dat: s.dat + DATA_W'(off),
                                 sel: {SEL_W{1'b1}}};
               port_exp[p]   = s.exp + DATA_W'(off);
               pending[p]    = 1'b1;
            end
         end
         if (grant_at < cycles + 1)
            grant_at = cycles + 1;
      end
   endtask

   // New inputs from the models on the falling edge
   task automatic drive_models();
      if (stim_on && (idx < NUM_ENTRIES) && (pending == '0) && !hreq_on && !afu_active)
      begin
         start_entry(stim[idx]);
         idx++;
      end
      if (!hreq_on && (pending != '0) && (cycles >= grant_at))
      begin
         cur_win   = next_winner();
         last_win  = cur_win;
         hreq_on   = 1'b1;
         host_wait = int'($urandom_range(3, 0));
      end
      host_rsp = '0;
      acking   = 1'b0;
      if (hreq_on && (host_wait == 0))
      begin
         acking       = 1'b1;
         host_rsp.ack = 1'b1;
         if (host_req.req.we)
            host_store[host_req.req.adr] = host_req.req.dat;
         else
            host_rsp.dat = host_store.exists(host_req.req.adr) ?
                           host_store[host_req.req.adr] : fill_word(host_req.req.adr);
      end
      else if (hreq_on)
         host_wait--;
      for (int p = 0; p < NUM_PORTS; p++)
         port_req[p] = pending[p] ? port_drive[p] : '0;
      lm_afu_req = afu_active ? afu_cur : '0;
      // Memory bank with random waitrequest and fixed read latency
      mem_wait   = (($urandom % 3) == 0);
      lm_mem_rsp = '0;
      lm_mem_rsp.waitrequest = mem_wait;
      for (int i = RD_DEPTH; i > 0; i--)
         rdv_pipe[i] = rdv_pipe[i-1];
      rdv_pipe[0] = 1'b0;
      if ((lat_due.size() > 0) && (lat_due[0] == cycles))
      begin
         lm_mem_rsp.readdatavalid = 1'b1;
         lm_mem_rsp.readdata      = lat_word.pop_front();
         rdv_pipe[0]              = 1'b1;
         void'(lat_due.pop_front());
      end
   endtask

   // Outputs have settled after the drive and the model state moves on
   task automatic check_outputs();
      host_req_t exp_hreq;
      wb_rsp_t   exp_prsp;
      avmm_rsp_t exp_arsp;
      avmm_req_t exp_mreq;
      logic      accepted;
      exp_hreq = '0;
      if (hreq_on)
      begin
         exp_hreq.req = port_drive[cur_win];
         exp_hreq.tag = port_tag_t'(INSTANCE_BASE + cur_win);
      end
      check_host_req("host_req", host_req, exp_hreq);
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         exp_prsp = '0;
         if (acking && (p == cur_win))
         begin
            exp_prsp.ack = 1'b1;
            exp_prsp.dat = port_drive[p].we ? '0 : port_exp[p];
         end
         check_wb_rsp($sformatf("port_rsp[%0d]", p), port_rsp[p], exp_prsp);
      end
      if (acking)
      begin
         pending[cur_win] = 1'b0;
         hreq_on          = 1'b0;
         grant_at         = cycles + 2;
      end
      exp_arsp = '0;
      exp_arsp.waitrequest   = stage_full && mem_wait;
      exp_arsp.readdatavalid = rdv_pipe[RD_DEPTH];
      if (rdv_pipe[RD_DEPTH])
      begin
         if (rd_exp_q.size() == 0)
         begin
            $display("read data returned with no memory read outstanding");
            abort_run();
         end
         else
            exp_arsp.readdata = rd_exp_q.pop_front();
      end
      check_avmm_rsp("lm_afu_rsp", lm_afu_rsp, exp_arsp);
      exp_mreq = stage_full ? stage_req : '0;
      check_avmm_req("lm_mem_req", lm_mem_req, exp_mreq);
      if (stage_full && !mem_wait)
      begin
         if (stage_req.write)
            mem_store[stage_req.address] = stage_req.writedata;
         else
         begin
            lat_due.push_back(cycles + MEM_LAT);
            lat_word.push_back(mem_store.exists(stage_req.address) ?
                               mem_store[stage_req.address] : fill_word(stage_req.address));
         end
      end
      accepted   = afu_active && !exp_arsp.waitrequest;
      stage_full = accepted || (stage_full && mem_wait);
      if (accepted)
      begin
         stage_req  = afu_cur;
         afu_active = 1'b0;
         if (afu_cur.read)
            rd_exp_q.push_back(afu_exp);
      end
   endtask

   task automatic tick();
      @(negedge Clk_100);
      cycles++;
      if (cycles > CYCLE_LIMIT)
      begin
         $display("timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
         abort_run();
      end
      else if (!reset)
      begin
         drive_models();
         #1;
         check_outputs();
      end
   endtask

   // ==================================================================
   // Main sequence
   // ==================================================================
   initial
   begin
      void'($urandom(32'h4d642eed));
      reset      = 1'b1;
      host_rsp   = '0;
      lm_afu_req = '0;
      lm_mem_rsp = '0;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         port_req[p]   = '0;
         port_drive[p] = '0;
         port_exp[p]   = '0;
      end
      for (int i = 0; i <= RD_DEPTH; i++)
         rdv_pipe[i] = 1'b0;
      {pending, hreq_on, acking, afu_active, stage_full, mem_wait, stim_on} = '0;
      {cur_win, grant_at, host_wait, idx, cycles} = '0;
      last_win  = NUM_PORTS - 1;
      afu_cur   = '0;
      stage_req = '0;
      afu_exp   = '0;
      // mem, all, port, we, address, data, expected read data
      stim = '{
         '{1'b0, 1'b0, 2'd0, 1'b1, 32'h0000_0100, 32'h1111_0000, 32'h0},
         '{1'b0, 1'b0, 2'd0, 1'b0, 32'h0000_0100, 32'h0,         32'h1111_0000},
         '{1'b0, 1'b0, 2'd1, 1'b1, 32'h0000_0104, 32'h2222_0001, 32'h0},
         '{1'b0, 1'b0, 2'd1, 1'b0, 32'h0000_0104, 32'h0,         32'h2222_0001},
         '{1'b0, 1'b0, 2'd2, 1'b1, 32'h0000_0108, 32'h3333_0002, 32'h0},
         '{1'b0, 1'b0, 2'd2, 1'b0, 32'h0000_0108, 32'h0,         32'h3333_0002},
         '{1'b0, 1'b0, 2'd1, 1'b1, 32'h0000_010c, 32'h4444_0003, 32'h0},
         '{1'b0, 1'b1, 2'd0, 1'b1, 32'h0000_0200, 32'ha0a0_0000, 32'h0},
         '{1'b0, 1'b1, 2'd0, 1'b0, 32'h0000_0200, 32'h0,         32'ha0a0_0000},
         '{1'b0, 1'b0, 2'd0, 1'b0, 32'h0000_010c, 32'h0,         32'h4444_0003},
         '{1'b0, 1'b1, 2'd0, 1'b1, 32'h0000_0300, 32'h5a5a_0010, 32'h0},
         '{1'b0, 1'b1, 2'd0, 1'b0, 32'h0000_0300, 32'h0,         32'h5a5a_0010},
         '{1'b1, 1'b0, 2'd0, 1'b1, 32'h0000_0040, 32'hdead_be00, 32'h0},
         '{1'b1, 1'b0, 2'd0, 1'b1, 32'h0000_0044, 32'hcafe_0001, 32'h0},
         '{1'b1, 1'b0, 2'd0, 1'b0, 32'h0000_0040, 32'h0,         32'hdead_be00},
         '{1'b1, 1'b0, 2'd0, 1'b0, 32'h0000_0044, 32'h0,         32'hcafe_0001},
         '{1'b1, 1'b0, 2'd0, 1'b1, 32'h0000_0040, 32'h1234_5678, 32'h0},
         '{1'b1, 1'b0, 2'd0, 1'b0, 32'h0000_0040, 32'h0,         32'h1234_5678}
      };
      repeat (10) tick();
      reset = 1'b0;
      // Idle cycle with outputs still in their reset state
      tick();
      stim_on = 1'b1;
      while (!drained())
         tick();
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/green_shell_sva.sv
/*
 * Handshake assertions on the host channel multiplexer
 * Bound into every host_chan_mux instance
 */
`timescale 1ns/1ps
`default_nettype none

module host_mux_sva
#(
   parameter int NUM_PORTS = 3
)
(
   input logic                 Clk_100,
   input logic                 reset,
   input shell_pkg::wb_rsp_t   port_rsp [NUM_PORTS],
   input shell_pkg::host_req_t host_req,
   input shell_pkg::wb_rsp_t   host_rsp
);

   logic [NUM_PORTS-1:0] port_ack;

   always_comb
   begin
      for (int p = 0; p < NUM_PORTS; p++)
         port_ack[p] = port_rsp[p].ack;
   end

   // One requester served at a time
   ack_one_port: assert property (@(posedge Clk_100) disable iff (reset)
      $onehot0(port_ack)) else $error("more than one port ack in a cycle");

   host_stb_cyc: assert property (@(posedge Clk_100) disable iff (reset)
      host_req.req.stb |-> host_req.req.cyc) else $error("host stb without cyc");

   // Request frozen until the host acknowledges it
   host_req_held: assert property (@(posedge Clk_100) disable iff (reset)
      (host_req.req.cyc && !host_rsp.ack) |=> $stable(host_req))
      else $error("host request changed before ack");

   ack_from_host: assert property (@(posedge Clk_100) disable iff (reset)
      (|port_ack) |-> host_rsp.ack) else $error("port ack without host ack");

endmodule

bind host_chan_mux host_mux_sva
#(
   .NUM_PORTS (NUM_PORTS)
)
mux_sva
(
   .Clk_100  (Clk_100),
   .reset    (reset),
   .port_rsp (port_rsp),
   .host_req (host_req),
   .host_rsp (host_rsp)
);

`default_nettype wire

// File: hw/green_shell_top.sv
/*
 * Shell top level
 * Host channel multiplexer and local memory bridge
 */
`timescale 1ns/1ps
`default_nettype none

module green_shell_top
#(
   parameter int NUM_PORTS           = 3,
   parameter int INSTANCE_BASE       = 1,
   parameter int READDATA_PIPE_DEPTH = 2
)
(
   input  logic                 Clk_100,
   input  logic                 reset,

   // Requester ports
   input  shell_pkg::wb_req_t   port_req [NUM_PORTS],
   output shell_pkg::wb_rsp_t   port_rsp [NUM_PORTS],

   // Upstream host channel
   output shell_pkg::host_req_t host_req,
   input  shell_pkg::wb_rsp_t   host_rsp,

   // Local memory, accelerator side
   input  shell_pkg::avmm_req_t lm_afu_req,
   output shell_pkg::avmm_rsp_t lm_afu_rsp,

   // Local memory, bank side
   output shell_pkg::avmm_req_t lm_mem_req,
   input  shell_pkg::avmm_rsp_t lm_mem_rsp
);

   // ==================================================================
   // Host channel
   // ==================================================================
   host_chan_mux
   #(
      .NUM_PORTS     (NUM_PORTS),
      .INSTANCE_BASE (INSTANCE_BASE)
   )
   host_mux
   (
      .Clk_100  (Clk_100),
      .reset    (reset),
      .port_req (port_req),
      .port_rsp (port_rsp),
      .host_req (host_req),
      .host_rsp (host_rsp)
   );

   // ==================================================================
   // Local memory bank
   // ==================================================================
   local_mem_bridge
   #(
      .READDATA_PIPE_DEPTH (READDATA_PIPE_DEPTH)
   )
   mem_bridge
   (
      .Clk_100    (Clk_100),
      .reset      (reset),
      .lm_afu_req (lm_afu_req),
      .lm_afu_rsp (lm_afu_rsp),
      .lm_mem_req (lm_mem_req),
      .lm_mem_rsp (lm_mem_rsp)
   );

endmodule

`default_nettype wire

// File: hw/local_mem_bridge.sv
/*
 * Local memory bridge on an Avalon-MM bank
 * Held request stage under waitrequest and a fixed-depth
 * read-data pipeline
 */
`timescale 1ns/1ps
`default_nettype none

module local_mem_bridge
#(
   parameter int READDATA_PIPE_DEPTH = 2
)
(
   input  logic                 Clk_100,
   input  logic                 reset,

   // Accelerator side
   input  shell_pkg::avmm_req_t lm_afu_req,
   output shell_pkg::avmm_rsp_t lm_afu_rsp,

   // Memory bank side
   output shell_pkg::avmm_req_t lm_mem_req,
   input  shell_pkg::avmm_rsp_t lm_mem_rsp
);

   import shell_pkg::*;

   typedef logic [DATA_W-1:0] data_word_t;

   // Request stage
   logic       afu_req_valid;
   logic       req_hold;
   logic       req_valid;
   avmm_req_t  req_q;

   // Read-data chain, index 0 is the memory side
   logic       rd_valid [READDATA_PIPE_DEPTH+1];
   data_word_t rd_data  [READDATA_PIPE_DEPTH+1];

   // ==================================================================
   // Request path
   // ==================================================================
   assign afu_req_valid = lm_afu_req.read | lm_afu_req.write;

   // Stage is stuck while its request has not been taken by the bank
   assign req_hold = req_valid & lm_mem_rsp.waitrequest;

   pipe_stage
   #(
      .payload_t (avmm_req_t)
   )
   req_stage
   (
      .Clk_100   (Clk_100),
      .reset     (reset),
      .in_valid  (afu_req_valid),
      .in_data   (lm_afu_req),
      .hold      (req_hold),
      .out_valid (req_valid),
      .out_data  (req_q)
   );

   // Strobes come from occupancy, stale payload is never issued
   always_comb
   begin
      lm_mem_req       = req_q;
      lm_mem_req.read  = req_q.read & req_valid;
      lm_mem_req.write = req_q.write & req_valid;
   end

   // ==================================================================
   // Read-data path
   // ==================================================================
   assign rd_valid[0] = lm_mem_rsp.readdatavalid;
   assign rd_data[0]  = lm_mem_rsp.readdata;

   // Plain shift chain, one beat in flight per stage
   for (genvar s = 0; s < READDATA_PIPE_DEPTH; s++)
   begin : g_rd_pipe
      pipe_stage
      #(
         .payload_t (data_word_t)
      )
      rd_stage
      (
         .Clk_100   (Clk_100),
         .reset     (reset),
         .in_valid  (rd_valid[s]),
         .in_data   (rd_data[s]),
         .hold      (1'b0),
         .out_valid (rd_valid[s+1]),
         .out_data  (rd_data[s+1])
      );
   end

   always_comb
   begin
      lm_afu_rsp.waitrequest   = req_hold;
      lm_afu_rsp.readdatavalid = rd_valid[READDATA_PIPE_DEPTH];
      lm_afu_rsp.readdata      = rd_data[READDATA_PIPE_DEPTH];
   end

endmodule

`default_nettype wire

// File: hw/host_chan_mux.sv
/*
 * Host channel multiplexer
 * Round-robin arbiter over Wishbone classic requester ports,
 * tagged upstream request register and ack routing
 */
`timescale 1ns/1ps
`default_nettype none

module host_chan_mux
#(
   parameter int NUM_PORTS     = 3,
   parameter int INSTANCE_BASE = 1
)
(
   input  logic                 Clk_100,
   input  logic                 reset,

   // Requester side
   input  shell_pkg::wb_req_t   port_req [NUM_PORTS],
   output shell_pkg::wb_rsp_t   port_rsp [NUM_PORTS],

   // Upstream host channel
   output shell_pkg::host_req_t host_req,
   input  shell_pkg::wb_rsp_t   host_rsp
);

   import shell_pkg::*;

   localparam int PORT_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

   // Arbiter state
   logic              busy;
   logic [PORT_W-1:0] rr_ptr;
   logic [PORT_W-1:0] grant_idx;

   // Winner of the current search
   logic              pick_valid;
   logic [PORT_W-1:0] pick_idx;
   logic [PORT_W-1:0] next_ptr;

   host_req_t         host_req_q;

   // ==================================================================
   // Round-robin search
   // ==================================================================

   // rr_ptr holds the port searched first, one past the last winner
   always_comb
   begin
      int cand;

      pick_valid = 1'b0;
      pick_idx   = '0;
      for (int i = 0; i < NUM_PORTS; i++)
      begin
         cand = int'(rr_ptr) + i;
         if (cand >= NUM_PORTS)
            cand = cand - NUM_PORTS;
         if (!pick_valid && port_req[cand].cyc && port_req[cand].stb)
         begin
            pick_valid = 1'b1;
            pick_idx   = PORT_W'(cand);
         end
      end
   end

   assign next_ptr = (pick_idx == PORT_W'(NUM_PORTS - 1)) ? '0 : pick_idx + 1'b1;

   // ==================================================================
   // Grant and release
   // ==================================================================
   always_ff @(posedge Clk_100)
   begin
      if (reset)
      begin
         busy      <= 1'b0;
         rr_ptr    <= '0;
         grant_idx <= '0;
      end
      else if (!busy)
      begin
         if (pick_valid)
         begin
            busy      <= 1'b1;
            grant_idx <= pick_idx;
            rr_ptr    <= next_ptr;
         end
      end
      else if (host_rsp.ack)
      begin
         // Released on the edge after ack, one idle cycle follows
         busy <= 1'b0;
      end
   end

   // Captured once at grant, the master holds its fields until ack
   always_ff @(posedge Clk_100)
   begin
      if (!busy && pick_valid)
      begin
         host_req_q.req <= port_req[pick_idx];
         host_req_q.tag <= port_tag_t'(INSTANCE_BASE + int'(pick_idx));
      end
   end

   // Strobes follow the grant so the request drops right after ack
   always_comb
   begin
      host_req         = host_req_q;
      host_req.req.cyc = busy;
      host_req.req.stb = busy;
   end

   // ==================================================================
   // Response routing
   // ==================================================================

   // Only the granted port sees ack and data, the others stay quiet
   always_comb
   begin
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         port_rsp[p].ack = 1'b0;
         port_rsp[p].dat = '0;
         if (busy && (grant_idx == PORT_W'(p)))
         begin
            port_rsp[p].ack = host_rsp.ack;
            port_rsp[p].dat = host_rsp.dat;
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/pipe_stage.sv
/*
 * Register slice for any payload type, with valid and hold
 */
`timescale 1ns/1ps
`default_nettype none

module pipe_stage
#(
   parameter type payload_t = logic
)
(
   input  logic     Clk_100,
   input  logic     reset,

   input  logic     in_valid,
   input  payload_t in_data,

   // Keeps the current content while high
   input  logic     hold,

   output logic     out_valid,
   output payload_t out_data
);

   // Occupancy
   always_ff @(posedge Clk_100)
   begin
      if (reset)
         out_valid <= 1'b0;
      else if (!hold)
         out_valid <= in_valid;
   end

   // Payload, only loaded with a valid word
   always_ff @(posedge Clk_100)
   begin
      if (!hold && in_valid)
         out_data <= in_data;
   end

endmodule

`default_nettype wire

// File: hw/shell_pkg.sv
/*
 * Shared widths and bus types for the shell
 * Wishbone classic request and response, tagged upstream request
 * Avalon-MM memory request and response
 */
`default_nettype none

package shell_pkg;

   // ==================================================================
   // Widths
   // ==================================================================
   localparam int ADDR_W    = 32;
   localparam int DATA_W    = 32;
   localparam int SEL_W     = DATA_W / 8;
   localparam int MAX_PORTS = 8;

   // Instance number carried upstream
   typedef logic [$clog2(MAX_PORTS)-1:0] port_tag_t;

   // ==================================================================
   // Host channel, Wishbone classic
   // ==================================================================
   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
      logic [SEL_W-1:0]  sel;
   } wb_req_t;

   typedef struct packed {
      logic              ack;
      logic [DATA_W-1:0] dat;
   } wb_rsp_t;

   // Request plus the tag of the port that issued it
   typedef struct packed {
      wb_req_t   req;
      port_tag_t tag;
   } host_req_t;

   // ==================================================================
   // Local memory, Avalon-MM
   // ==================================================================
   typedef struct packed {
      logic              read;
      logic              write;
      logic [ADDR_W-1:0] address;
      logic [DATA_W-1:0] writedata;
      logic [SEL_W-1:0]  byteenable;
   } avmm_req_t;

   typedef struct packed {
      logic              waitrequest;
      logic              readdatavalid;
      logic [DATA_W-1:0] readdata;
   } avmm_rsp_t;

endpackage

`default_nettype wire
